/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axil_host_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
source/axil_pkg.sv
source/host_pkg.sv
source/fifo_small.sv
source/axil_fifo_master.sv
source/axil_ram_slave.sv
source/axil_host_top.sv
verification/tb_axil_host_top.sv

/* source/axil_fifo_master.sv */
module axil_fifo_master
  import axil_pkg::*;
  import host_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,

  input  host_req_t  req_i,
  input  logic       req_v_i,
  output logic       req_ready_o,

  output host_resp_t resp_o,
  output logic       resp_v_o,
  input  logic       resp_ready_i,

  output axil_aw_t   aw_o,
  output logic       aw_v_o,
  input  logic       aw_ready_i,

  output axil_w_t    w_o,
  output logic       w_v_o,
  input  logic       w_ready_i,

  input  axil_b_t    b_i,
  input  logic       b_v_i,
  output logic       b_ready_o,

  output axil_ar_t   ar_o,
  output logic       ar_v_o,
  input  logic       ar_ready_i,

  input  axil_r_t    r_i,
  input  logic       r_v_i,
  output logic       r_ready_o
);

  typedef struct packed {
    logic                       w;
    logic [axil_addr_width-1:0] addr;
  } addr_entry_t;

  logic        wdata_ready;
  logic        addr_ready;
  logic        ret_ready;
  logic        req_take;
  axil_w_t     w_in;
  addr_entry_t addr_in;
  addr_entry_t addr_head;
  logic        addr_v;
  logic        addr_yumi;
  logic        ret_w;
  logic        ret_v;
  logic        ret_yumi;

  assign req_ready_o = wdata_ready & addr_ready & ret_ready;
  assign req_take    = req_v_i & req_ready_o;

  assign w_in    = '{data: req_i.data, strb: req_i.mask};
  assign addr_in = '{w: req_i.w, addr: req_i.addr};

  fifo_small #(.width($bits(axil_w_t)), .els(fifo_els)) wdata_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (w_in),
    .v_i     (req_take & req_i.w),  // Reads carry no data beat
    .ready_o (wdata_ready),
    .data_o  (w_o),
    .v_o     (w_v_o),
    .yumi_i  (w_v_o & w_ready_i)
  );

  fifo_small #(.width($bits(addr_entry_t)), .els(fifo_els)) addr_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (addr_in),
    .v_i     (req_take),
    .ready_o (addr_ready),
    .data_o  (addr_head),
    .v_o     (addr_v),
    .yumi_i  (addr_yumi)
  );

  // Keeps the order of response kinds for the host
  fifo_small #(.width(1), .els(fifo_els)) return_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (req_i.w),
    .v_i     (req_take),
    .ready_o (ret_ready),
    .data_o  (ret_w),
    .v_o     (ret_v),
    .yumi_i  (ret_yumi)
  );

  assign aw_v_o = addr_v & addr_head.w;
  assign aw_o   = '{addr: addr_head.addr, prot: axil_prot_dsn};
  assign ar_v_o = addr_v & ~addr_head.w;
  assign ar_o   = '{addr: addr_head.addr, prot: axil_prot_dsn};

  assign addr_yumi = (aw_v_o & aw_ready_i) | (ar_v_o & ar_ready_i);

  // Only the channel named by the head entry may answer
  assign resp_v_o    = ret_v & (ret_w ? b_v_i : r_v_i);
  assign resp_o.data = r_i.data;  // Don't care on writes

  assign b_ready_o = ret_v & ret_w & resp_ready_i;
  assign r_ready_o = ret_v & ~ret_w & resp_ready_i;
  assign ret_yumi  = resp_v_o & resp_ready_i;

endmodule

/* source/axil_host_top.sv */
module axil_host_top
  import axil_pkg::*;
  import host_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  host_req_t  req_i,
  input  logic       req_v_i,
  output logic       req_ready_o,
  output host_resp_t resp_o,
  output logic       resp_v_o,
  input  logic       resp_ready_i
);

  axil_aw_t aw;
  logic     aw_v;
  logic     aw_ready;
  axil_w_t  w;
  logic     w_v;
  logic     w_ready;
  axil_b_t  b;
  logic     b_v;
  logic     b_ready;
  axil_ar_t ar;
  logic     ar_v;
  logic     ar_ready;
  axil_r_t  r;
  logic     r_v;
  logic     r_ready;

  axil_fifo_master master (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .req_v_i      (req_v_i),
    .req_ready_o  (req_ready_o),
    .resp_o       (resp_o),
    .resp_v_o     (resp_v_o),
    .resp_ready_i (resp_ready_i),
    .aw_o         (aw),
    .aw_v_o       (aw_v),
    .aw_ready_i   (aw_ready),
    .w_o          (w),
    .w_v_o        (w_v),
    .w_ready_i    (w_ready),
    .b_i          (b),
    .b_v_i        (b_v),
    .b_ready_o    (b_ready),
    .ar_o         (ar),
    .ar_v_o       (ar_v),
    .ar_ready_i   (ar_ready),
    .r_i          (r),
    .r_v_i        (r_v),
    .r_ready_o    (r_ready)
  );

  axil_ram_slave ram (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .aw_i       (aw),
    .aw_v_i     (aw_v),
    .aw_ready_o (aw_ready),
    .w_i        (w),
    .w_v_i      (w_v),
    .w_ready_o  (w_ready),
    .b_o        (b),
    .b_v_o      (b_v),
    .b_ready_i  (b_ready),
    .ar_i       (ar),
    .ar_v_i     (ar_v),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_v_o      (r_v),
    .r_ready_i  (r_ready)
  );

endmodule

/* source/axil_pkg.sv */
package axil_pkg;

  localparam int axil_addr_width = 32;
  localparam int axil_data_width = 32;
  localparam int axil_strb_width = axil_data_width / 8;

  localparam logic [2:0] axil_prot_dsn = 3'b000;  // Data, secure, unprivileged

  localparam logic [1:0] axil_resp_okay   = 2'b00;
  localparam logic [1:0] axil_resp_slverr = 2'b10;

  typedef struct packed {
    logic [axil_addr_width-1:0] addr;
    logic [2:0]                 prot;
  } axil_aw_t;

  typedef struct packed {
    logic [axil_data_width-1:0] data;
    logic [axil_strb_width-1:0] strb;  // One bit per byte lane
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [axil_addr_width-1:0] addr;
    logic [2:0]                 prot;
  } axil_ar_t;

  typedef struct packed {
    logic [axil_data_width-1:0] data;
    logic [1:0]                 resp;
  } axil_r_t;

endpackage

/* source/axil_ram_slave.sv */
module axil_ram_slave
  import axil_pkg::*;
  import host_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,

  input  axil_aw_t aw_i,
  input  logic     aw_v_i,
  output logic     aw_ready_o,

  input  axil_w_t  w_i,
  input  logic     w_v_i,
  output logic     w_ready_o,

  output axil_b_t  b_o,
  output logic     b_v_o,
  input  logic     b_ready_i,

  input  axil_ar_t ar_i,
  input  logic     ar_v_i,
  output logic     ar_ready_o,

  output axil_r_t  r_o,
  output logic     r_v_o,
  input  logic     r_ready_i
);

  logic [axil_data_width-1:0]   mem [ram_words];
  logic [$clog2(ram_words)-1:0] aw_idx;
  logic [$clog2(ram_words)-1:0] ar_idx;
  logic                         aw_oor;
  logic                         ar_oor;
  logic                         wr_fire;
  logic                         rd_fire;

  // Word select sits just above the byte offset
  assign aw_idx = aw_i.addr[$clog2(axil_strb_width) +: $clog2(ram_words)];
  assign ar_idx = ar_i.addr[$clog2(axil_strb_width) +: $clog2(ram_words)];

  // Any bit above the word select means out of range
  assign aw_oor = |aw_i.addr[axil_addr_width-1:$clog2(axil_strb_width)+$clog2(ram_words)];
  assign ar_oor = |ar_i.addr[axil_addr_width-1:$clog2(axil_strb_width)+$clog2(ram_words)];

  assign wr_fire    = aw_v_i & w_v_i & ~b_v_o;
  assign aw_ready_o = wr_fire;  // AW and W taken together
  assign w_ready_o  = wr_fire;

  assign ar_ready_o = ~r_v_o;
  assign rd_fire    = ar_v_i & ar_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < ram_words; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_fire) begin
      for (int i = 0; i < axil_strb_width; i++) begin
        if (w_i.strb[i]) begin
          mem[aw_idx][8*i +: 8] <= w_i.data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_v_o <= 1'b0;
    end else if (wr_fire) begin
      b_v_o <= 1'b1;
    end else if (b_ready_i) begin
      b_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_o.resp <= aw_oor ? axil_resp_slverr : axil_resp_okay;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_v_o <= 1'b0;
    end else if (rd_fire) begin
      r_v_o <= 1'b1;
    end else if (r_ready_i) begin
      r_v_o <= 1'b0;
    end
  end

  // Read sees the old word if a write lands in the same cycle
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      r_o.data <= mem[ar_idx];
      r_o.resp <= ar_oor ? axil_resp_slverr : axil_resp_okay;
    end
  end

endmodule

/* source/fifo_small.sv */
module fifo_small #(
  parameter int width = 8,
  parameter int els   = 4
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [width-1:0] data_i,
  input  logic             v_i,
  output logic             ready_o,
  output logic [width-1:0] data_o,
  output logic             v_o,
  input  logic             yumi_i
);

  typedef logic [$clog2(els)-1:0]   ptr_t;
  typedef logic [$clog2(els+1)-1:0] cnt_t;

  logic [width-1:0] mem [els];
  ptr_t             rd_ptr;
  ptr_t             wr_ptr;
  cnt_t             count;
  logic             wr_en;
  logic             rd_en;

  function automatic ptr_t ptr_next(ptr_t p);
    return (p == ptr_t'(els - 1)) ? '0 : p + 1'b1;
  endfunction

  assign ready_o = (count != cnt_t'(els));
  assign v_o     = (count != '0);
  assign data_o  = mem[rd_ptr];  // Head entry, valid when v_o

  assign wr_en = v_i & ready_o;
  assign rd_en = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

/* source/host_pkg.sv */
package host_pkg;

  import axil_pkg::*;

  localparam int fifo_els  = 4;   // Entries per bridge FIFO
  localparam int ram_words = 16;  // Power of two, address wraps on it

  typedef struct packed {
    logic                       w;     // High for a write
    logic [axil_addr_width-1:0] addr;
    logic [axil_data_width-1:0] data;
    logic [axil_strb_width-1:0] mask;
  } host_req_t;

  typedef struct packed {
    logic [axil_data_width-1:0] data;
  } host_resp_t;

endpackage

/* verification/tb_axil_host_top.sv */
module tb_axil_host_top
  import axil_pkg::*;
  import host_pkg::*;
();

  localparam int idle_latency = 3;  // Accept edge through consume edge, inclusive

  logic       clk;
  logic       rst;
  host_req_t  req;
  logic       req_v;
  logic       req_ready;
  host_resp_t resp;
  logic       resp_v;
  logic       resp_ready;

  logic [axil_data_width-1:0] model [ram_words];
  logic                       exp_w_q [$];
  logic [axil_data_width-1:0] exp_d_q [$];
  logic [15:0] lfsr = 16'd80;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cyc = 0;
  int last_accept_cyc = 0;
  int last_resp_cyc = 0;
  int writes_sent = 0;
  int writes_back = 0;

  axil_host_top uut (
    .clk_i        (clk),
    .rst_i        (rst),
    .req_i        (req),
    .req_v_i      (req_v),
    .req_ready_o  (req_ready),
    .resp_o       (resp),
    .resp_v_o     (resp_v),
    .resp_ready_i (resp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois form, taps 16,14,13,11
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
    end
    return v;
  endfunction

  function automatic logic pick_ready(int mode);
    if (mode == 2) begin
      return 1'(rand_bits(1));  // Random stall
    end
    return (mode == 1);
  endfunction

  function automatic int word_idx(logic [31:0] addr);
    return int'((addr >> 2) % ram_words);
  endfunction

  function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] data, logic [3:0] mask);
    logic [31:0] v;
    v = old;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        v[8*i +: 8] = data[8*i +: 8];
      end
    end
    return v;
  endfunction

  // Drives one falling edge, accounts for what the next rising edge transfers
  task automatic step(input logic v, input host_req_t r, input logic rdy, output logic took);
    logic                       exp_w;
    logic [axil_data_width-1:0] exp_d;
    took = v && req_ready;
    req_v = v;
    req = r;
    resp_ready = rdy;
    if (resp_v && rdy) begin
      if (exp_w_q.size() == 0) begin
        $display("A response arrived with no request outstanding");
        errors++;
      end else begin
        exp_w = exp_w_q.pop_front();
        exp_d = exp_d_q.pop_front();
        last_resp_cyc = cyc;
        if (exp_w) begin
          writes_back++;  // Data ignored on writes
        end else begin
          assert (resp.data == exp_d) else begin
            $display("ERR resp_o.data got %08h expected %08h", resp.data, exp_d);
            errors++;
          end
        end
      end
    end
    if (took) begin
      last_accept_cyc = cyc;
      exp_w_q.push_back(r.w);
      if (r.w) begin
        model[word_idx(r.addr)] = merge(model[word_idx(r.addr)], r.data, r.mask);
        exp_d_q.push_back('0);
      end else begin
        exp_d_q.push_back(model[word_idx(r.addr)]);
      end
    end
    cyc++;
    @(negedge clk);
  endtask

  task automatic issue(input host_req_t r, input int mode);
    logic took;
    int   n;
    took = 1'b0;
    n = 0;
    while (!took && n < 50) begin
      step(1'b1, r, pick_ready(mode), took);
      n++;
    end
    if (!took) begin
      $display("Request at address %08h was not accepted within 50 cycles", r.addr);
      errors++;
    end
  endtask

  task automatic drain(input int mode);
    logic took;
    int   n;
    n = 0;
    while (exp_w_q.size() != 0 && n < 200) begin
      step(1'b0, '0, pick_ready(mode), took);
      n++;
    end
    if (exp_w_q.size() != 0) begin
      $display("Responses were still missing after 200 cycles");
      errors++;
    end
  endtask

  task automatic report(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - err_start);
    end
  endtask

  task automatic test_reset_state();
    int e;
    e = errors;
    assert (req_ready == 1'b1) else begin
      $display("ERR req_ready_o got %0h expected 1", req_ready);
      errors++;
    end
    assert (resp_v == 1'b0) else begin
      $display("ERR resp_v_o got %0h expected 0", resp_v);
      errors++;
    end
    report("reset_state", e);
  endtask

  task automatic test_write_read();
    host_req_t r;
    int        e;
    int        lat;
    e = errors;
    r.w = 1'b1;
    r.addr = 32'h0000_0008;
    r.data = rand_bits(32);
    r.mask = 4'hF;
    issue(r, 1);
    drain(1);
    r.w = 1'b0;
    issue(r, 1);
    drain(1);
    lat = last_resp_cyc - last_accept_cyc + 1;
    assert (lat == idle_latency) else begin
      $display("ERR read latency got %0h expected %0h", lat, idle_latency);
      errors++;
    end
    report("write_read", e);
  endtask

  task automatic test_byte_merge();
    host_req_t r;
    int        e;
    e = errors;
    for (int i = 0; i < 6; i++) begin
      r.w = 1'b1;
      r.addr = 32'((i * 7) % 32) << 2;  // Word indices past ram_words too
      r.data = rand_bits(32);
      r.mask = 4'(rand_bits(4));
      issue(r, 1);
      r.w = 1'b0;
      r.addr = r.addr ^ 32'(ram_words * 4);  // Aliased word after wrap
      issue(r, 1);
      drain(1);
    end
    report("byte_merge", e);
  endtask

  task automatic test_back_pressure();
    host_req_t                  r;
    logic [axil_data_width-1:0] held;
    logic                       took;
    int                         e;
    e = errors;
    for (int i = 0; i < fifo_els; i++) begin
      r.w = 1'b0;
      r.addr = 32'(i * 28);
      r.data = '0;
      r.mask = '0;
      issue(r, 0);
    end
    assert (req_ready == 1'b0) else begin
      $display("ERR req_ready_o got %0h expected 0", req_ready);
      errors++;
    end
    held = exp_d_q[0];  // Model word of the oldest read
    for (int i = 0; i < 6; i++) begin
      step(1'b0, '0, 1'b0, took);
      assert (resp_v == 1'b1) else begin
        $display("ERR resp_v_o got %0h expected 1 while stalled", resp_v);
        errors++;
      end
      assert (resp.data == held) else begin
        $display("ERR resp_o.data got %08h expected %08h while stalled", resp.data, held);
        errors++;
      end
    end
    drain(1);
    report("back_pressure", e);
  endtask

  task automatic test_mixed_traffic();
    host_req_t r;
    logic      took;
    int        e;
    e = errors;
    writes_sent = 0;
    writes_back = 0;
    for (int i = 0; i < 24; i++) begin
      r.w = 1'(rand_bits(1));
      r.addr = rand_bits(5) << 2;
      r.data = rand_bits(32);
      r.mask = 4'(rand_bits(4));
      if (r.w) begin
        writes_sent++;
      end
      issue(r, 2);
    end
    drain(2);
    // Idle tail catches any extra response
    for (int i = 0; i < 4; i++) begin
      step(1'b0, '0, 1'b1, took);
    end
    assert (writes_back == writes_sent) else begin
      $display("ERR write responses got %0h expected %0h", writes_back, writes_sent);
      errors++;
    end
    report("mixed_traffic", e);
  endtask

  initial begin
    rst = 1'b1;
    req = '0;
    req_v = 1'b0;
    resp_ready = 1'b0;
    for (int i = 0; i < ram_words; i++) begin
      model[i] = '0;  // RAM clears at reset
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    test_reset_state();
    test_write_read();
    test_byte_merge();
    test_back_pressure();
    test_mixed_traffic();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #200000;
    $display("The watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

endmodule
